// File: core_cfg_pkg.sv
package core_cfg_pkg;

    localparam int XLEN     = 32;
    localparam int PC_W     = 14; // 16 KB instruction space
    localparam int NUM_REGS = 32;

    typedef logic [PC_W-1:0] pc_t;
    typedef logic [XLEN-1:0] word_t;

    localparam pc_t   RESET_PC  = '0;
    localparam word_t NOP_INSTR = 32'h0000_0013; // ADDI x0, x0, 0

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    localparam funct7_t F7_ALT = 7'b0100000; // SUB, SRA and SRAI

    // Anything outside these opcodes decodes as a no-op
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000, // ADD/SUB
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101, // SRL/SRA
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10, // LUI
        LINK   = 4'd11  // Return address in operand a
    } alu_op_e;

endpackage

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_isa_pkg::instr_t  instr_i,
    input  logic                redirect_i,
    input  core_cfg_pkg::pc_t   redirect_pc_i,
    output core_cfg_pkg::pc_t   pc_o,
    output rv_isa_pkg::instr_t  if_instr_o,
    output core_cfg_pkg::pc_t   if_pc_o,
    output logic                if_valid_o
);

    core_cfg_pkg::pc_t pc_next;

    assign pc_next = redirect_i ? redirect_pc_i : pc_o + core_cfg_pkg::pc_t'(4);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc_o       <= core_cfg_pkg::RESET_PC;
            if_valid_o <= 1'b0;
        end else begin
            pc_o       <= pc_next;
            if_valid_o <= !redirect_i; // Kill the slot behind a taken jump
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (redirect_i) begin
            if_instr_o <= core_cfg_pkg::NOP_INSTR;
        end else begin
            if_instr_o <= instr_i;
        end
        if_pc_o <= pc_o;
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::reg_addr_t rs1_i,
    input  rv_isa_pkg::reg_addr_t rs2_i,
    input  logic                  we_i,
    input  rv_isa_pkg::reg_addr_t wrd_i,
    input  core_cfg_pkg::word_t   wdata_i,
    output core_cfg_pkg::word_t   rdata1_o,
    output core_cfg_pkg::word_t   rdata2_o
);

    core_cfg_pkg::word_t regs [core_cfg_pkg::NUM_REGS];

    // Read port with x0 forced to zero
    function automatic core_cfg_pkg::word_t read_port(input rv_isa_pkg::reg_addr_t ra);
        core_cfg_pkg::word_t val;
        if (ra == '0) begin
            val = '0;
        end else if (we_i && (wrd_i == ra)) begin
            val = wdata_i; // Same-cycle bypass
        end else begin
            val = regs[ra];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < core_cfg_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wrd_i != '0)) begin
            regs[wrd_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata1_o = read_port(rs1_i);
        rdata2_o = read_port(rs2_i);
    end

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::instr_t    if_instr_i,
    input  core_cfg_pkg::pc_t     if_pc_i,
    input  logic                  if_valid_i,
    input  core_cfg_pkg::word_t   rdata1_i,
    input  core_cfg_pkg::word_t   rdata2_i,
    output rv_isa_pkg::reg_addr_t rs1_o,
    output rv_isa_pkg::reg_addr_t rs2_o,
    output logic                  redirect_o,
    output core_cfg_pkg::pc_t     redirect_pc_o,
    output logic                  ex_valid_o,
    output rv_isa_pkg::alu_op_e   ex_alu_op_o,
    output core_cfg_pkg::word_t   ex_op_a_o,
    output core_cfg_pkg::word_t   ex_op_b_o,
    output rv_isa_pkg::reg_addr_t ex_rd_o
);

    rv_isa_pkg::opcode_e   opcode;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::funct7_t   funct7;
    rv_isa_pkg::reg_addr_t rd;

    core_cfg_pkg::word_t imm_i;
    core_cfg_pkg::word_t imm_b;
    core_cfg_pkg::word_t imm_u;
    core_cfg_pkg::word_t imm_j;
    core_cfg_pkg::word_t link;
    core_cfg_pkg::word_t jalr_sum;
    core_cfg_pkg::pc_t   pc_offset;

    rv_isa_pkg::alu_op_e alu_op;
    core_cfg_pkg::word_t op_a;
    core_cfg_pkg::word_t op_b;
    logic                wr_en;
    logic                take;
    logic                br_cond;

    // ALU select for OP and OP-IMM
    function automatic rv_isa_pkg::alu_op_e alu_sel(input rv_isa_pkg::funct3_t f3,
                                                    input logic alt,
                                                    input logic reg_op);
        rv_isa_pkg::alu_op_e op;
        case (rv_isa_pkg::alu_f3_e'(f3))
            rv_isa_pkg::F3_ADD:  op = (alt && reg_op) ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
            rv_isa_pkg::F3_SLL:  op = rv_isa_pkg::SLL;
            rv_isa_pkg::F3_SLT:  op = rv_isa_pkg::SLT;
            rv_isa_pkg::F3_SLTU: op = rv_isa_pkg::SLTU;
            rv_isa_pkg::F3_XOR:  op = rv_isa_pkg::XOR;
            rv_isa_pkg::F3_SR:   op = alt ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
            rv_isa_pkg::F3_OR:   op = rv_isa_pkg::OR;
            default:             op = rv_isa_pkg::AND;
        endcase
        return op;
    endfunction

    assign opcode = rv_isa_pkg::opcode_e'(if_instr_i[6:0]);
    assign rd     = if_instr_i[11:7];
    assign funct3 = if_instr_i[14:12];
    assign rs1_o  = if_instr_i[19:15];
    assign rs2_o  = if_instr_i[24:20];
    assign funct7 = if_instr_i[31:25];

    assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                    if_instr_i[30:25], if_instr_i[11:8], 1'b0};
    assign imm_u = {if_instr_i[31:12], 12'b0};
    assign imm_j = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                    if_instr_i[20], if_instr_i[30:21], 1'b0};

    assign link     = core_cfg_pkg::word_t'(if_pc_i) + 32'd4;
    assign jalr_sum = rdata1_i + imm_i;

    always_comb begin
        case (rv_isa_pkg::branch_e'(funct3))
            rv_isa_pkg::BEQ:  br_cond = (rdata1_i == rdata2_i);
            rv_isa_pkg::BNE:  br_cond = (rdata1_i != rdata2_i);
            rv_isa_pkg::BLT:  br_cond = ($signed(rdata1_i) < $signed(rdata2_i));
            rv_isa_pkg::BGE:  br_cond = ($signed(rdata1_i) >= $signed(rdata2_i));
            rv_isa_pkg::BLTU: br_cond = (rdata1_i < rdata2_i);
            rv_isa_pkg::BGEU: br_cond = (rdata1_i >= rdata2_i);
            default:          br_cond = 1'b0; // 010/011 are not branches
        endcase
    end

    always_comb begin
        alu_op = rv_isa_pkg::ADD;
        op_a   = rdata1_i;
        op_b   = rdata2_i;
        wr_en  = 1'b0;
        take   = 1'b0;
        case (opcode)
            rv_isa_pkg::OP: begin
                alu_op = alu_sel(funct3, funct7 == rv_isa_pkg::F7_ALT, 1'b1);
                wr_en  = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                alu_op = alu_sel(funct3, funct7 == rv_isa_pkg::F7_ALT, 1'b0);
                op_b   = imm_i;
                wr_en  = 1'b1;
            end
            rv_isa_pkg::LUI: begin
                alu_op = rv_isa_pkg::PASS_B;
                op_b   = imm_u;
                wr_en  = 1'b1;
            end
            rv_isa_pkg::JAL, rv_isa_pkg::JALR: begin
                alu_op = rv_isa_pkg::LINK;
                op_a   = link;
                wr_en  = 1'b1;
                take   = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                take = br_cond;
            end
            default: begin
                wr_en = 1'b0; // Unsupported opcodes retire silently
            end
        endcase
    end

    assign pc_offset = (opcode == rv_isa_pkg::JAL) ? imm_j[core_cfg_pkg::PC_W-1:0]
                                                   : imm_b[core_cfg_pkg::PC_W-1:0];

    assign redirect_o    = if_valid_i && take;
    assign redirect_pc_o = (opcode == rv_isa_pkg::JALR)
                         ? {jalr_sum[core_cfg_pkg::PC_W-1:1], 1'b0}
                         : if_pc_i + pc_offset;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= if_valid_i && wr_en;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        ex_alu_op_o <= alu_op;
        ex_op_a_o   <= op_a;
        ex_op_b_o   <= op_b;
        ex_rd_o     <= rd;
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid_i,
    input  rv_isa_pkg::alu_op_e   ex_alu_op_i,
    input  core_cfg_pkg::word_t   ex_op_a_i,
    input  core_cfg_pkg::word_t   ex_op_b_i,
    input  rv_isa_pkg::reg_addr_t ex_rd_i,
    output logic                  wb_en_o,
    output rv_isa_pkg::reg_addr_t wb_rd_o,
    output core_cfg_pkg::word_t   wb_data_o
);

    logic [4:0]                     shamt;
    logic signed [core_cfg_pkg::XLEN-1:0] sra_res;
    logic                           lt_signed;
    logic                           lt_unsigned;
    core_cfg_pkg::word_t            alu_res;

    assign shamt       = ex_op_b_i[4:0]; // Low five bits only
    assign sra_res     = $signed(ex_op_a_i) >>> shamt;
    assign lt_signed   = $signed(ex_op_a_i) < $signed(ex_op_b_i);
    assign lt_unsigned = ex_op_a_i < ex_op_b_i;

    always_comb begin
        case (ex_alu_op_i)
            rv_isa_pkg::ADD:    alu_res = ex_op_a_i + ex_op_b_i;
            rv_isa_pkg::SUB:    alu_res = ex_op_a_i - ex_op_b_i;
            rv_isa_pkg::SLL:    alu_res = ex_op_a_i << shamt;
            rv_isa_pkg::SLT:    alu_res = {31'b0, lt_signed};
            rv_isa_pkg::SLTU:   alu_res = {31'b0, lt_unsigned};
            rv_isa_pkg::XOR:    alu_res = ex_op_a_i ^ ex_op_b_i;
            rv_isa_pkg::SRL:    alu_res = ex_op_a_i >> shamt;
            rv_isa_pkg::SRA:    alu_res = sra_res;
            rv_isa_pkg::OR:     alu_res = ex_op_a_i | ex_op_b_i;
            rv_isa_pkg::AND:    alu_res = ex_op_a_i & ex_op_b_i;
            rv_isa_pkg::PASS_B: alu_res = ex_op_b_i;
            rv_isa_pkg::LINK:   alu_res = ex_op_a_i; // PC+4 from decode
            default:            alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= ex_valid_i && (ex_rd_i != '0); // x0 writes dropped here
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= ex_rd_i;
        wb_data_o <= alu_res;
    end

endmodule

// File: rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::instr_t    instr_i,
    output core_cfg_pkg::pc_t     pc_o,
    output logic                  wb_en_o,
    output rv_isa_pkg::reg_addr_t wb_rd_o,
    output core_cfg_pkg::word_t   wb_data_o
);

    rv_isa_pkg::instr_t    if_instr;
    core_cfg_pkg::pc_t     if_pc;
    logic                  if_valid;
    logic                  redirect;
    core_cfg_pkg::pc_t     redirect_pc;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    core_cfg_pkg::word_t   rdata1;
    core_cfg_pkg::word_t   rdata2;
    logic                  ex_valid;
    rv_isa_pkg::alu_op_e   ex_alu_op;
    core_cfg_pkg::word_t   ex_op_a;
    core_cfg_pkg::word_t   ex_op_b;
    rv_isa_pkg::reg_addr_t ex_rd;

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_i       (instr_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .pc_o          (pc_o),
        .if_instr_o    (if_instr),
        .if_pc_o       (if_pc),
        .if_valid_o    (if_valid)
    );

    // Write port driven straight from the writeback register
    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .we_i     (wb_en_o),
        .wrd_i    (wb_rd_o),
        .wdata_i  (wb_data_o),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .if_instr_i    (if_instr),
        .if_pc_i       (if_pc),
        .if_valid_i    (if_valid),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_valid_o    (ex_valid),
        .ex_alu_op_o   (ex_alu_op),
        .ex_op_a_o     (ex_op_a),
        .ex_op_b_o     (ex_op_b),
        .ex_rd_o       (ex_rd)
    );

    execute_stage u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_valid_i  (ex_valid),
        .ex_alu_op_i (ex_alu_op),
        .ex_op_a_i   (ex_op_a),
        .ex_op_b_i   (ex_op_b),
        .ex_rd_i     (ex_rd),
        .wb_en_o     (wb_en_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int HALF_PERIOD     = 10;
    localparam int MEM_WORDS       = 64;
    localparam int PROG_LEN        = 46;
    localparam int EXP_LEN         = 25;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 4 + 20;

    localparam logic [6:0] OPC_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [31:0] SKIPPED = 32'hfff0_0f93; // ADDI x31, x0, -1 must never retire

    logic                  clk;
    logic                  rst_n;
    rv_isa_pkg::instr_t    instr;
    core_cfg_pkg::pc_t     pc;
    logic                  wb_en;
    rv_isa_pkg::reg_addr_t wb_rd;
    core_cfg_pkg::word_t   wb_data;
    logic                  past_end;

    logic [31:0] prog   [MEM_WORDS];
    logic [36:0] exp_wb [EXP_LEN]; // {rd, data}
    int          errors;
    int          seen;
    int          tail;
    logic        found;

    rv_core_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_i   (instr),
        .pc_o      (pc),
        .wb_en_o   (wb_en),
        .wb_rd_o   (wb_rd),
        .wb_data_o (wb_data)
    );

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
        errors++;
    endtask

    // Returns with found low once the program has drained without a writeback
    task automatic next_writeback(output logic hit);
        int drain;
        drain = 0;
        hit   = 1'b0;
        while (!hit && drain < 4) begin
            @(negedge clk);
            if (wb_en) begin
                hit = 1'b1;
            end else if (past_end) begin
                drain++;
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = core_cfg_pkg::NOP_INSTR;
        end
        prog[0]  = i_format(12'hffb, 5'd0, 3'b000, 5'd1, OPC_IMM);  // ADDI x1, x0, -5
        prog[1]  = i_format(12'h003, 5'd0, 3'b000, 5'd2, OPC_IMM);  // ADDI x2, x0, 3
        prog[2]  = {20'h80000, 5'd3, 7'b0110111};                   // LUI x3, 0x80000
        prog[3]  = r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd4);       // ADD
        prog[4]  = r_format(7'h20, 5'd2, 5'd1, 3'b000, 5'd5);       // SUB
        prog[5]  = r_format(7'h00, 5'd2, 5'd2, 3'b001, 5'd6);       // SLL x6, x2, x2
        prog[6]  = r_format(7'h00, 5'd2, 5'd1, 3'b010, 5'd7);       // SLT
        prog[7]  = r_format(7'h00, 5'd2, 5'd1, 3'b011, 5'd8);       // SLTU
        prog[8]  = r_format(7'h00, 5'd2, 5'd1, 3'b100, 5'd9);       // XOR
        prog[9]  = r_format(7'h00, 5'd2, 5'd1, 3'b101, 5'd10);      // SRL
        prog[10] = r_format(7'h20, 5'd2, 5'd1, 3'b101, 5'd11);      // SRA
        prog[11] = r_format(7'h00, 5'd2, 5'd1, 3'b110, 5'd12);      // OR
        prog[12] = r_format(7'h00, 5'd2, 5'd1, 3'b111, 5'd13);      // AND
        prog[13] = r_format(7'h20, 5'd2, 5'd3, 3'b101, 5'd14);      // SRA x14, x3, x2
        prog[14] = i_format(12'hfff, 5'd2, 3'b100, 5'd15, OPC_IMM); // XORI -1
        prog[15] = i_format(12'hffc, 5'd1, 3'b010, 5'd16, OPC_IMM); // SLTI -4
        prog[16] = i_format(12'hfff, 5'd2, 3'b011, 5'd17, OPC_IMM); // SLTIU -1
        prog[17] = i_format(12'h004, 5'd1, 3'b001, 5'd18, OPC_IMM); // SLLI 4
        prog[18] = i_format(12'h01c, 5'd1, 3'b101, 5'd19, OPC_IMM); // SRLI 28
        prog[19] = i_format(12'h005, 5'd2, 3'b000, 5'd0, OPC_IMM);  // ADDI x0, x2, 5
        prog[20] = i_format(12'h401, 5'd1, 3'b101, 5'd20, OPC_IMM); // SRAI 1
        prog[21] = r_format(7'h00, 5'd2, 5'd0, 3'b000, 5'd21);      // ADD x21, x0, x2
        prog[22] = b_format(13'd8, 5'd2, 5'd2, 3'b000);             // BEQ taken
        prog[23] = SKIPPED;
        prog[24] = b_format(13'd8, 5'd2, 5'd1, 3'b000);             // BEQ not taken
        prog[25] = b_format(13'd8, 5'd2, 5'd1, 3'b001);             // BNE taken
        prog[26] = SKIPPED;
        prog[27] = b_format(13'd8, 5'd2, 5'd2, 3'b001);
        prog[28] = b_format(13'd8, 5'd2, 5'd1, 3'b100);             // BLT taken
        prog[29] = SKIPPED;
        prog[30] = b_format(13'd8, 5'd1, 5'd2, 3'b100);
        prog[31] = b_format(13'd8, 5'd1, 5'd2, 3'b101);             // BGE taken
        prog[32] = SKIPPED;
        prog[33] = b_format(13'd8, 5'd2, 5'd1, 3'b101);
        prog[34] = b_format(13'd8, 5'd1, 5'd2, 3'b110);             // BLTU taken
        prog[35] = SKIPPED;
        prog[36] = b_format(13'd8, 5'd2, 5'd1, 3'b110);
        prog[37] = b_format(13'd8, 5'd2, 5'd1, 3'b111);             // BGEU taken
        prog[38] = SKIPPED;
        prog[39] = b_format(13'd8, 5'd1, 5'd2, 3'b111);
        prog[40] = i_format(12'h0b8, 5'd0, 3'b000, 5'd27, OPC_IMM); // ADDI x27, x0, 184
        prog[41] = j_format(21'd8, 5'd25);                          // JAL x25, +8
        prog[42] = SKIPPED;
        prog[43] = i_format(12'hffd, 5'd27, 3'b000, 5'd26, OPC_JALR); // 181 rounds to 180
        prog[44] = SKIPPED;
        prog[45] = i_format(12'h055, 5'd0, 3'b000, 5'd28, OPC_IMM);
    endtask

    task automatic load_expected();
        exp_wb[0]  = {5'd1, 32'hffff_fffb};
        exp_wb[1]  = {5'd2, 32'h0000_0003};
        exp_wb[2]  = {5'd3, 32'h8000_0000};
        exp_wb[3]  = {5'd4, 32'hffff_fffe};
        exp_wb[4]  = {5'd5, 32'hffff_fff8};
        exp_wb[5]  = {5'd6, 32'h0000_0018};
        exp_wb[6]  = {5'd7, 32'h0000_0001};  // -5 < 3 signed
        exp_wb[7]  = {5'd8, 32'h0000_0000};
        exp_wb[8]  = {5'd9, 32'hffff_fff8};
        exp_wb[9]  = {5'd10, 32'h1fff_ffff};
        exp_wb[10] = {5'd11, 32'hffff_ffff};
        exp_wb[11] = {5'd12, 32'hffff_fffb};
        exp_wb[12] = {5'd13, 32'h0000_0003};
        exp_wb[13] = {5'd14, 32'hf000_0000};
        exp_wb[14] = {5'd15, 32'hffff_fffc};
        exp_wb[15] = {5'd16, 32'h0000_0001};
        exp_wb[16] = {5'd17, 32'h0000_0001};
        exp_wb[17] = {5'd18, 32'hffff_ffb0};
        exp_wb[18] = {5'd19, 32'h0000_000f};
        exp_wb[19] = {5'd20, 32'hffff_fffd};
        exp_wb[20] = {5'd21, 32'h0000_0003};
        exp_wb[21] = {5'd27, 32'h0000_00b8};
        exp_wb[22] = {5'd25, 32'h0000_00a8}; // Link of JAL at 164
        exp_wb[23] = {5'd26, 32'h0000_00b0}; // Link of JALR at 172
        exp_wb[24] = {5'd28, 32'h0000_0055};
    endtask

    assign past_end = (pc >= core_cfg_pkg::pc_t'(PROG_LEN * 4));

    // Instruction memory, same-cycle read
    always_comb begin
        if (pc[13:8] == '0) begin
            instr = prog[pc[7:2]];
        end else begin
            instr = core_cfg_pkg::NOP_INSTR;
        end
    end

    // Fetch addresses stay word aligned after a JALR
    always @(negedge clk) begin
        if (!rst_n && pc[1:0] != 2'b00) begin
            $display("Fetch address 0x%04h on pc_o is not word aligned", pc);
            errors++;
        end
    end

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock periods", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        errors = 0;
        seen   = 0;
        rst_n  = 1'b1;
        load_program();
        load_expected();
        @(posedge clk);
        @(negedge clk);
        if (pc !== core_cfg_pkg::RESET_PC) begin
            report_mismatch("pc_o", 32'(pc), 32'(core_cfg_pkg::RESET_PC));
        end
        if (wb_en !== 1'b0) begin
            report_mismatch("wb_en_o", 32'(wb_en), 32'h0);
        end
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        if (pc !== core_cfg_pkg::RESET_PC) begin
            report_mismatch("pc_o", 32'(pc), 32'(core_cfg_pkg::RESET_PC));
        end
        if (wb_en !== 1'b0) begin
            report_mismatch("wb_en_o", 32'(wb_en), 32'h0);
        end
        @(negedge clk);
        if (pc !== core_cfg_pkg::RESET_PC + core_cfg_pkg::pc_t'(4)) begin
            report_mismatch("pc_o", 32'(pc), 32'(core_cfg_pkg::RESET_PC) + 32'd4);
        end

        for (int k = 0; k < EXP_LEN; k++) begin
            next_writeback(found);
            if (!found) begin
                $display("Missing writebacks: only %0d of %0d arrived", seen, EXP_LEN);
                errors++;
                break;
            end
            seen++;
            if (wb_rd !== exp_wb[k][36:32]) begin
                report_mismatch("wb_rd_o", 32'(wb_rd), 32'(exp_wb[k][36:32]));
            end
            if (wb_data !== exp_wb[k][31:0]) begin
                report_mismatch("wb_data_o", wb_data, exp_wb[k][31:0]);
            end
        end

        tail = 0;
        while (tail < 4) begin
            @(negedge clk);
            if (wb_en) begin
                $display("Unexpected writeback to x%0d after the expected list ended", wb_rd);
                errors++;
            end
            if (past_end) begin
                tail++;
            end
        end

        $display("Checked %0d of %0d writebacks, %0d errors", seen, EXP_LEN, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
core_cfg_pkg.sv
rv_isa_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
rv_core_top.sv
tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the RV32I core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_rv_core -f vlog.f -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_core > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "Result: PASSED" sim.log; then
    exit 0
fi
echo "Simulation reported failure"
exit 1
